//--- hdl/fetch_pkg.sv
//////////////////////////////////////////////////
// shared front end types.
// pc, instruction word and parcel widths,
// pc generator state machine encoding.
//////////////////////////////////////////////////

package fetch_pkg;

	// fetch or instruction address.
	typedef logic [63:0] pc_t;

	// instruction word as fetched.
	// upper half is zero for compressed ones.
	typedef logic [31:0] instr_t;

	// one 16-bit parcel.
	typedef logic [15:0] half_t;

	// pc generator states.
	typedef enum logic {
		// issue held pc, nothing in flight.
		pc_start,
		// next pc follows from returning response.
		pc_stream
	} pc_state_t;

	// instruction lengths in bytes.
	localparam pc_t RVC_LEN = 64'd2;
	localparam pc_t STD_LEN = 64'd4;

endpackage

//--- hdl/pc_gen.sv
//////////////////////////////////////////////////
// program counter generator.
// one halfword aligned fetch address per cycle,
// reset, redirect and stall handling.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
	parameter pc_t RESET_PC = 64'h0000_0000_8000_0000
) (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic redirect,
	input  pc_t  redirect_pc,
	input  logic rsp_valid,
	input  logic rsp_rvc,
	output logic imem_req,
	output pc_t  imem_addr,
	output logic rsp_expect
);

	pc_state_t state_q;
	// address of the last issued request, or the one to issue in pc_start.
	pc_t pc_q;
	pc_t step;
	logic advance;

	// length of the instruction now returning.
	assign step = rsp_rvc ? RVC_LEN : STD_LEN;

	// step only once the previous response is seen.
	assign advance = (state_q == pc_stream) & rsp_valid;

	// same cycle the data returns, next address is known.
	assign imem_addr = advance ? pc_q + step : pc_q;

	// no new request while the queue is full.
	assign imem_req = ~stall;

	// a request went out last cycle and was not cancelled.
	assign rsp_expect = (state_q == pc_stream);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= pc_start;
			pc_q <= RESET_PC;
		end else if (redirect) begin
			// restart at the new target.
			state_q <= pc_start;
			pc_q <= redirect_pc;
		end else if (stall) begin
			// response arriving now is dropped by fetch,
			// so pc_q keeps its address for a refetch.
			state_q <= pc_start;
		end else begin
			state_q <= pc_stream;
			pc_q <= imem_addr;
		end
	end

endmodule

//--- hdl/instr_align.sv
//////////////////////////////////////////////////
// memory response checker.
// drops stale responses, tags compressed
// parcels and clears their upper half.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_align import fetch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   redirect,
	input  logic   rsp_expect,
	input  instr_t imem_rdata,
	input  pc_t    req_pc,
	output logic   rsp_valid,
	output instr_t rsp_instr,
	output pc_t    rsp_pc,
	output logic   rsp_rvc
);

	// pc of the request issued last cycle.
	pc_t req_pc_q;
	// no redirect between request and response.
	logic live_q;
	// low parcel of the returned word.
	half_t lo_half;

	// memory answers one cycle later, so the
	// address is simply delayed by one.
	always_ff @(posedge clk) begin
		req_pc_q <= req_pc;
	end

	// a redirect at the request edge makes the
	// response belong to the old stream.
	always_ff @(posedge clk) begin
		if (rst) begin
			live_q <= 1'b0;
		end else begin
			live_q <= ~redirect;
		end
	end

	assign lo_half = imem_rdata[15:0];

	// rvc unless both low bits are set.
	assign rsp_rvc = (lo_half[1:0] != 2'b11);

	// upper parcel belongs to the next instruction.
	assign rsp_instr = rsp_rvc ? {16'h0000, lo_half} : imem_rdata;

	assign rsp_pc = req_pc_q;

	// expected and not stale.
	assign rsp_valid = rsp_expect & live_q;

endmodule

//--- hdl/instr_fetch.sv
//////////////////////////////////////////////////
// fetch register stage.
// holds instruction, pc and rvc flag toward
// the queue, with flush and back-pressure.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_fetch import fetch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   flush,
	input  logic   full,
	input  logic   rsp_valid,
	input  instr_t rsp_instr,
	input  pc_t    rsp_pc,
	input  logic   rsp_rvc,
	output logic   push,
	output instr_t entry_instr,
	output pc_t    entry_pc,
	output logic   entry_rvc
);

	logic valid_q;
	instr_t instr_q;
	pc_t pc_q;
	logic rvc_q;

	// valid reloads on every non-full cycle.
	// a held entry therefore goes out once.
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid_q <= 1'b0;
		end else if (!full) begin
			valid_q <= rsp_valid;
		end
	end

	// payload follows the same load rule.
	always_ff @(posedge clk) begin
		if (flush) begin
			instr_q <= '0;
			pc_q <= '0;
			rvc_q <= 1'b0;
		end else if (!full) begin
			instr_q <= rsp_instr;
			pc_q <= rsp_pc;
			rvc_q <= rsp_rvc;
		end
	end

	// only offered when the queue has room.
	assign push = valid_q & ~full;

	assign entry_instr = instr_q;
	assign entry_pc = pc_q;
	assign entry_rvc = rvc_q;

endmodule

//--- hdl/instr_fifo.sv
//////////////////////////////////////////////////
// instruction queue between fetch and decode.
// circular buffer, flushable, valid/ready out.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_fifo import fetch_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   flush,
	input  logic   push,
	input  instr_t entry_instr,
	input  pc_t    entry_pc,
	input  logic   entry_rvc,
	input  logic   dec_ready,
	output logic   full,
	output logic   dec_valid,
	output instr_t dec_instr,
	output pc_t    dec_pc,
	output logic   dec_rvc
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	// one extra bit to tell full from empty.
	typedef logic [PTR_W:0] cnt_t;

	instr_t instr_mem [FIFO_DEPTH];
	pc_t pc_mem [FIFO_DEPTH];
	logic rvc_mem [FIFO_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic wr_en;
	logic rd_en;

	assign full = (count == cnt_t'(FIFO_DEPTH));
	assign dec_valid = (count != '0);

	// a write needs a free slot.
	assign wr_en = push & ~full;
	assign rd_en = dec_valid & dec_ready;

	// pointers wrap on their own, depth is a power of two.
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave count alone.
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			instr_mem[wr_ptr] <= entry_instr;
			pc_mem[wr_ptr] <= entry_pc;
			rvc_mem[wr_ptr] <= entry_rvc;
		end
	end

	// head of queue.
	assign dec_instr = instr_mem[rd_ptr];
	assign dec_pc = pc_mem[rd_ptr];
	assign dec_rvc = rvc_mem[rd_ptr];

endmodule

//--- hdl/frontend_top.sv
//////////////////////////////////////////////////
// instruction front end top level.
// pc generator, aligner, fetch stage and queue
// between the memory and decode ports.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_top import fetch_pkg::*; #(
	parameter pc_t RESET_PC = 64'h0000_0000_8000_0000,
	parameter int FIFO_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   redirect,
	input  pc_t    redirect_pc,
	input  instr_t imem_rdata,
	input  logic   dec_ready,
	output logic   imem_req,
	output pc_t    imem_addr,
	output logic   dec_valid,
	output instr_t dec_instr,
	output pc_t    dec_pc,
	output logic   dec_rvc
);

	// generator to aligner.
	logic rsp_expect;

	// aligner to fetch stage and generator.
	logic rsp_valid;
	instr_t rsp_instr;
	pc_t rsp_pc;
	logic rsp_rvc;

	// fetch stage to queue.
	logic push;
	instr_t entry_instr;
	pc_t entry_pc;
	logic entry_rvc;

	// queue full doubles as the fetch stall.
	logic full;

	pc_gen #(
		.RESET_PC(RESET_PC)
	) u_pc_gen (
		.clk(clk),
		.rst(rst),
		.stall(full),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.rsp_valid(rsp_valid),
		.rsp_rvc(rsp_rvc),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.rsp_expect(rsp_expect)
	);

	// request address doubles as the response pc.
	instr_align u_instr_align (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.rsp_expect(rsp_expect),
		.imem_rdata(imem_rdata),
		.req_pc(imem_addr),
		.rsp_valid(rsp_valid),
		.rsp_instr(rsp_instr),
		.rsp_pc(rsp_pc),
		.rsp_rvc(rsp_rvc)
	);

	instr_fetch u_instr_fetch (
		.clk(clk),
		.rst(rst),
		.flush(redirect),
		.full(full),
		.rsp_valid(rsp_valid),
		.rsp_instr(rsp_instr),
		.rsp_pc(rsp_pc),
		.rsp_rvc(rsp_rvc),
		.push(push),
		.entry_instr(entry_instr),
		.entry_pc(entry_pc),
		.entry_rvc(entry_rvc)
	);

	instr_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_instr_fifo (
		.clk(clk),
		.rst(rst),
		.flush(redirect),
		.push(push),
		.entry_instr(entry_instr),
		.entry_pc(entry_pc),
		.entry_rvc(entry_rvc),
		.dec_ready(dec_ready),
		.full(full),
		.dec_valid(dec_valid),
		.dec_instr(dec_instr),
		.dec_pc(dec_pc),
		.dec_rvc(dec_rvc)
	);

endmodule

//--- tests/frontend_properties.sv
//////////////////////////////////////////////////
// bound checks on the memory and decode
// handshakes and on reset behaviour.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_properties import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic redirect,
	input logic imem_req,
	input pc_t  imem_addr,
	input logic push,
	input logic dec_valid,
	input logic dec_ready,
	input pc_t  dec_pc
);

	// queue and fetch register empty after reset.
	reset_empty: assert property (@(posedge clk) rst |=> (!dec_valid && !push))
		else $error("dec_valid or push high in the cycle after reset");

	// fetch addresses stay on parcel boundaries.
	addr_aligned: assert property (@(posedge clk) disable iff (rst)
		imem_req |-> (imem_addr[0] == 1'b0))
		else $error("imem_addr not halfword aligned");

	// head of queue held while decode waits, unless flushed.
	head_stable: assert property (@(posedge clk) disable iff (rst)
		(dec_valid && !dec_ready) |=> (!dec_valid || $stable(dec_pc)))
		else $error("dec_pc changed while dec_valid was held");

	// a pushed entry lands in the queue unless flushed.
	push_kept: assert property (@(posedge clk) disable iff (rst)
		(push && !redirect) |=> dec_valid)
		else $error("push lost by the queue");

endmodule

bind frontend_top frontend_properties u_props (
	.clk(clk),
	.rst(rst),
	.redirect(redirect),
	.imem_req(imem_req),
	.imem_addr(imem_addr),
	.push(push),
	.dec_valid(dec_valid),
	.dec_ready(dec_ready),
	.dec_pc(dec_pc)
);

//--- tests/frontend_tb.sv
//////////////////////////////////////////////////
// front end testbench with memory model,
// program and expected stream tables,
// decode stalls and redirect tests.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_tb;
	import fetch_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 4;
	localparam pc_t TB_RESET_PC = 64'h0000_0000_8000_1000;
	localparam int TB_FIFO_DEPTH = 4;
	localparam int MEM_HW = 1024;
	localparam int TABLE_LEN = 16;
	// decode stalls stretch each entry by this many cycles at most.
	localparam int STALL_FACTOR = 12;
	localparam int WATCHDOG_CYCLES = 4 * (TABLE_LEN * STALL_FACTOR + RESET_CYCLES + 20);

	// program in fetch order, compressed words have a zero upper half.
	localparam instr_t PROG_INSTR [TABLE_LEN] = '{
		32'h0000_0513, 32'h0000_4505, 32'h00b5_0533, 32'h0000_0505,
		32'h0000_8082, 32'h00a1_3423, 32'h0000_6108, 32'hfe05_08e3,
		32'h0000_0001, 32'h0005_0593, 32'h0000_852e, 32'h02b5_0533,
		32'h0000_1141, 32'h0011_3c23, 32'h0000_4581, 32'h0000_006f
	};
	// compressed flag per entry.
	localparam logic PROG_RVC [TABLE_LEN] = '{
		1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0,
		1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0
	};

	logic clk = 1'b0;
	logic rst;
	logic redirect;
	pc_t redirect_pc;
	instr_t imem_rdata;
	logic dec_ready;
	logic imem_req;
	pc_t imem_addr;
	logic dec_valid;
	instr_t dec_instr;
	pc_t dec_pc;
	logic dec_rvc;

	// memory image in parcels.
	half_t mem [MEM_HW];
	// expected pc per table entry.
	pc_t exp_pc [TABLE_LEN];
	int idx;
	int redir_idx;
	// set once a pass or fail line is out.
	logic verdict_printed = 1'b0;
	logic req_s;
	pc_t addr_s;
	logic [9:0] hw_s;

	frontend_top #(
		.RESET_PC(TB_RESET_PC),
		.FIFO_DEPTH(TB_FIFO_DEPTH)
	) uut (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_rdata(imem_rdata),
		.dec_ready(dec_ready),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.dec_valid(dec_valid),
		.dec_instr(dec_instr),
		.dec_pc(dec_pc),
		.dec_rvc(dec_rvc)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// memory model, fixed one cycle latency.
	// request sampled mid-cycle, data driven after the edge.
	initial begin
		imem_rdata = '0;
		forever begin
			@(negedge clk);
			req_s = imem_req;
			addr_s = imem_addr;
			@(posedge clk);
			#DRIVE_DELAY;
			// no request, last word is held.
			if (req_s) begin
				hw_s = addr_s[10:1];
				imem_rdata = {mem[hw_s + 10'd1], mem[hw_s]};
			end
		end
	end

	// run limit.
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		verdict_printed = 1'b1;
		$display("timeout: the decode stream did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	// a run stopped by a failed assertion still ends with a fail line.
	final begin
		if (!verdict_printed) begin
			$display("ERRORS FOUND");
		end
	end

	task automatic check_val(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			verdict_printed = 1'b1;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value check failed");
		end
	endtask

	// fill every parcel, then lay the program out from the reset pc.
	task automatic load_program();
		int hw;
		for (int i = 0; i < MEM_HW; i++) begin
			mem[i] = half_t'(i) ^ 16'hc3a5;
		end
		hw = 0;
		for (int k = 0; k < TABLE_LEN; k++) begin
			exp_pc[k] = TB_RESET_PC + 64'(2 * hw);
			mem[hw] = PROG_INSTR[k][15:0];
			if (!PROG_RVC[k]) begin
				mem[hw + 1] = PROG_INSTR[k][31:16];
			end
			// length rule, 2 bytes compressed, 4 otherwise.
			hw += PROG_RVC[k] ? 1 : 2;
		end
	endtask

	// one decode transfer against the table.
	task automatic check_entry();
		check_val("dec_pc", dec_pc, exp_pc[idx]);
		check_val("dec_instr", 64'(dec_instr), 64'(PROG_INSTR[idx]));
		check_val("dec_rvc", 64'(dec_rvc), 64'(PROG_RVC[idx]));
		idx++;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		dec_ready = 1'b0;
		redirect = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		idx = 0;
	endtask

	// drive one cycle, then look at the transfer at the coming edge.
	task automatic step_cycle(input logic rdy, input logic redir);
		@(posedge clk);
		#DRIVE_DELAY;
		dec_ready = rdy;
		redirect = redir;
		redirect_pc = redir ? exp_pc[redir_idx] : '0;
		@(negedge clk);
		// a transfer at the redirect edge still belongs to the old stream.
		if (dec_valid && dec_ready) begin
			check_entry();
		end
		if (redir) begin
			idx = redir_idx;
		end
	endtask

	initial begin
		void'($urandom(32'ha03d));
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		dec_ready = 1'b0;
		idx = 0;
		redir_idx = 0;
		load_program();

		// reset pc on the first request, full stream with decode always ready.
		apply_reset();
		@(negedge clk);
		check_val("imem_req", 64'(imem_req), 64'd1);
		check_val("imem_addr", imem_addr, TB_RESET_PC);
		while (idx < TABLE_LEN) step_cycle(1'b1, 1'b0);

		// random decode stalls fill the queue.
		apply_reset();
		while (idx < TABLE_LEN) step_cycle((($urandom % 3) == 0), 1'b0);

		// redirect in mid-stream.
		apply_reset();
		redir_idx = 9;
		while (idx < 5) step_cycle(1'b1, 1'b0);
		step_cycle(1'b1, 1'b1);
		while (idx < TABLE_LEN) step_cycle(1'b1, 1'b0);

		// redirect while the queue is full and fetch stalled.
		apply_reset();
		redir_idx = 5;
		step_cycle(1'b0, 1'b0);
		while (imem_req) step_cycle(1'b0, 1'b0);
		repeat (2) step_cycle(1'b0, 1'b0);
		step_cycle(1'b0, 1'b1);
		while (idx < TABLE_LEN) step_cycle((($urandom % 2) == 0), 1'b0);

		verdict_printed = 1'b1;
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- filelist.f
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/instr_align.sv
hdl/instr_fetch.sv
hdl/instr_fifo.sv
hdl/frontend_top.sv
tests/frontend_properties.sv
tests/frontend_tb.sv

//--- Makefile
# Verilator build and run for the instruction front end testbench.

SIM = obj_dir/Vfrontend_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module frontend_tb \
		-f filelist.f --Mdir obj_dir

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
